// ==== Makefile ====
FLIST = lpif_link_top.f
TOP   = lpif_link_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/lpif_link_config.svh ====
`ifndef LPIF_LINK_CONFIG_SVH
`define LPIF_LINK_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Link geometry
////////////////////////////////////////////////////////////////////////////

// Number of parallel PHY lanes
`define LANE_COUNT 4

// Bits per lane word, strobe and marker included
`define LANE_WIDTH 24

////////////////////////////////////////////////////////////////////////////
// User side
////////////////////////////////////////////////////////////////////////////

// LPIF payload width, a multiple of 8
`define DATA_WIDTH 64

// Debug word counters wrap at this width
`define DBG_WIDTH 16

`endif

// ==== lpif_link_top.f ====
+incdir+include
src/lpif_link_pkg.sv
src/phy_lane_pkg.sv
src/link_auto_sync.sv
src/lane_stripe.sv
src/lpif_stream_pack.sv
src/lpif_link_top.sv
verif/lpif_link_tb.sv

// ==== src/lane_stripe.sv ====
`timescale 1ns/1ns

`include "lpif_link_config.svh"

module lane_stripe
  import phy_lane_pkg::*;
(
  input  logic       clk_wr,
  input  logic       arst_n,
  input  logic       tx_online_delay,
  input  link_word_t tx_link_word,
  output lane_bus_t  tx_lanes,
  input  lane_bus_t  rx_lanes,
  output link_word_t rx_link_word,
  output logic       rx_strobe_seen
);

  localparam int PAYLOAD_W   = $bits(lane_payload_t);
  localparam int STB_BIT     = 0;
  localparam int MRK_BIT     = 1;
  localparam int PAYLOAD_LSB = 2;
  localparam int LAST_LANE   = `LANE_COUNT - 1;

  lane_bus_t tx_lanes_next;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit striping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_lanes_next = '0;
    for (int i = 0; i < `LANE_COUNT; i++) begin
      tx_lanes_next.lane[i][`LANE_WIDTH-1:PAYLOAD_LSB] =
        tx_link_word[i*PAYLOAD_W +: PAYLOAD_W];
    end
    // Persistent strobe and marker
    tx_lanes_next.lane[0][STB_BIT]         = 1'b1;
    tx_lanes_next.lane[LAST_LANE][MRK_BIT] = 1'b1;
  end

  // Lanes stay quiet until auto sync lets the link go online
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_lanes <= '0;
    end else if (tx_online_delay) begin
      tx_lanes <= tx_lanes_next;
    end else begin
      tx_lanes <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive reassembly
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rx_link_word = '0;
    for (int i = 0; i < `LANE_COUNT; i++) begin
      rx_link_word[i*PAYLOAD_W +: PAYLOAD_W] =
        rx_lanes.lane[i][`LANE_WIDTH-1:PAYLOAD_LSB];
    end
  end

  // Lane 0 strobe qualifies the whole word
  assign rx_strobe_seen = rx_lanes.lane[0][STB_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_quiet_offline: assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    !tx_online_delay |=> (tx_lanes == '0)
  ) else $error("tx_lanes active after tx_online_delay was low");

endmodule

// ==== src/link_auto_sync.sv ====
`timescale 1ns/1ns

module link_auto_sync
  import phy_lane_pkg::*;
(
  input  logic   clk_wr,
  input  logic   arst_n,
  input  logic   tx_online,
  input  logic   rx_online,
  input  delay_t delay_x_value,
  input  delay_t delay_xz_value,
  input  delay_t delay_yz_value,
  output logic   tx_online_delay,
  output logic   rx_online_delay
);

  // Channel 0 is tx, channel 1 is rx
  localparam int NUM_CH = 2;

  // One extra bit holds the rx sum of two delays
  localparam int CNT_W = $bits(delay_t) + 1;

  logic [NUM_CH-1:0] online_in;
  logic [NUM_CH-1:0] online_out;
  logic [CNT_W-1:0]  load_val [NUM_CH];

  ////////////////////////////////////////////////////////////////////////////
  // Per channel delay values
  ////////////////////////////////////////////////////////////////////////////

  assign online_in = {rx_online, tx_online};

  assign load_val[0] = {1'b0, delay_xz_value};

  // Word alignment time plus the rx settle time
  assign load_val[1] = {1'b0, delay_x_value} + {1'b0, delay_yz_value};

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

  ////////////////////////////////////////////////////////////////////////////
  // Delay FSMs
  ////////////////////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_sync
    sync_state_e      state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        state <= SYNC_OFFLINE;
        cnt   <= '0;
      end else begin
        case (state)
          SYNC_OFFLINE: begin
            if (online_in[ch]) begin
              // Zero delay goes online at the same edge
              if (load_val[ch] == '0) begin
                state <= SYNC_ONLINE;
              end else begin
                state <= SYNC_COUNT;
                cnt   <= load_val[ch] - 1'b1;
              end
            end
          end
          SYNC_COUNT: begin
            if (!online_in[ch]) begin
              state <= SYNC_OFFLINE;
            end else if (cnt == '0) begin
              state <= SYNC_ONLINE;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
          SYNC_ONLINE: begin
            if (!online_in[ch]) begin
              state <= SYNC_OFFLINE;
            end
          end
          default: begin
            state <= SYNC_OFFLINE;
          end
        endcase
      end
    end

    assign online_out[ch] = (state == SYNC_ONLINE);

    // A dropped input takes the delayed level down by the next edge
    a_drop_follows: assert property (
      @(posedge clk_wr) disable iff (!arst_n)
      !online_in[ch] |=> !online_out[ch]
    ) else $error("online_delay of channel %0d stayed high after its input dropped", ch);
  end

endmodule

// ==== src/lpif_link_pkg.sv ====
`include "lpif_link_config.svh"

package lpif_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // LPIF stream fields
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] lpif_state_t;
  typedef logic [1:0] protid_t;
  typedef logic [`DATA_WIDTH-1:0] lpif_data_t;

  // Index of the first valid byte
  typedef logic [2:0] bstart_t;

  // One bit per data byte
  typedef logic [`DATA_WIDTH/8-1:0] bvalid_t;

  // Field order sets the bit layout on the link, valid lands in bit 0
  typedef struct packed {
    lpif_state_t state;
    protid_t     protid;
    lpif_data_t  data;
    bstart_t     bstart;
    bvalid_t     bvalid;
    logic        valid;
  } lpif_stream_t;

  ////////////////////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`DBG_WIDTH-1:0] dbg_count_t;

endpackage

// ==== src/lpif_link_top.sv ====
`timescale 1ns/1ns

module lpif_link_top
  import lpif_link_pkg::*;
  import phy_lane_pkg::*;
(
  input  logic         clk_wr,
  input  logic         arst_n,
  input  logic         tx_online,
  input  logic         rx_online,
  input  delay_t       delay_x_value,
  input  delay_t       delay_xz_value,
  input  delay_t       delay_yz_value,
  input  lpif_stream_t upstream,
  output lpif_stream_t downstream,
  output lane_bus_t    tx_lanes,
  input  lane_bus_t    rx_lanes,
  output dbg_count_t   tx_debug_status,
  output dbg_count_t   rx_debug_status
);

  logic       tx_online_delay;
  logic       rx_online_delay;
  link_word_t tx_link_word;
  link_word_t rx_link_word;
  logic       rx_strobe_seen;

  ////////////////////////////////////////////////////////////////////////////
  // Auto sync
  ////////////////////////////////////////////////////////////////////////////

  link_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PHY lanes
  ////////////////////////////////////////////////////////////////////////////

  lane_stripe u_lane_stripe (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online_delay (tx_online_delay),
    .tx_link_word    (tx_link_word),
    .tx_lanes        (tx_lanes),
    .rx_lanes        (rx_lanes),
    .rx_link_word    (rx_link_word),
    .rx_strobe_seen  (rx_strobe_seen)
  );

  ////////////////////////////////////////////////////////////////////////////
  // User streams
  ////////////////////////////////////////////////////////////////////////////

  lpif_stream_pack u_stream_pack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .upstream        (upstream),
    .tx_online_delay (tx_online_delay),
    .tx_link_word    (tx_link_word),
    .rx_link_word    (rx_link_word),
    .rx_strobe_seen  (rx_strobe_seen),
    .rx_online_delay (rx_online_delay),
    .downstream      (downstream),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status)
  );

endmodule

// ==== src/lpif_stream_pack.sv ====
`timescale 1ns/1ns

module lpif_stream_pack
  import lpif_link_pkg::*;
  import phy_lane_pkg::*;
(
  input  logic         clk_wr,
  input  logic         arst_n,
  input  lpif_stream_t upstream,
  input  logic         tx_online_delay,
  output link_word_t   tx_link_word,
  input  link_word_t   rx_link_word,
  input  logic         rx_strobe_seen,
  input  logic         rx_online_delay,
  output lpif_stream_t downstream,
  output dbg_count_t   tx_debug_status,
  output dbg_count_t   rx_debug_status
);

  localparam int STREAM_W = $bits(lpif_stream_t);

  lpif_stream_t rx_word;
  logic         rx_ok;
  logic         rx_take;

  ////////////////////////////////////////////////////////////////////////////
  // Pack and unpack
  ////////////////////////////////////////////////////////////////////////////

  // Spare link bits above the stream go out as zero
  assign tx_link_word = link_word_t'(upstream);

  assign rx_word = lpif_stream_t'(rx_link_word[STREAM_W-1:0]);
  assign rx_ok   = rx_online_delay && rx_strobe_seen;
  assign rx_take = rx_ok && rx_word.valid;

  // Fields hold while the receive side is not usable
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      downstream <= '0;
    end else begin
      downstream.valid <= rx_take;
      if (rx_ok) begin
        downstream.state  <= rx_word.state;
        downstream.protid <= rx_word.protid;
        downstream.data   <= rx_word.data;
        downstream.bstart <= rx_word.bstart;
        downstream.bvalid <= rx_word.bvalid;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Debug counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_debug_status <= '0;
      rx_debug_status <= '0;
    end else begin
      if (upstream.valid && tx_online_delay) begin
        tx_debug_status <= tx_debug_status + 1'b1;
      end
      if (rx_take) begin
        rx_debug_status <= rx_debug_status + 1'b1;
      end
    end
  end

  a_rx_gated: assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    !rx_online_delay |=> !downstream.valid
  ) else $error("downstream.valid high after rx_online_delay was low");

endmodule

// ==== src/phy_lane_pkg.sv ====
`include "lpif_link_config.svh"

package phy_lane_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lane side words
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 strobe, bit 1 marker, payload above
  typedef logic [`LANE_WIDTH-1:0] lane_word_t;
  typedef logic [`LANE_WIDTH-3:0] lane_payload_t;

  // All lane payloads back to back, lane 0 in the low bits
  typedef logic [`LANE_COUNT*(`LANE_WIDTH-2)-1:0] link_word_t;

  typedef struct packed {
    lane_word_t [`LANE_COUNT-1:0] lane;
  } lane_bus_t;

  ////////////////////////////////////////////////////////////////////////////
  // Auto sync
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] delay_t;

  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_COUNT,
    SYNC_ONLINE
  } sync_state_e;

endpackage

// ==== verif/lpif_link_tb.sv ====
`timescale 1ns/1ns

`include "lpif_link_config.svh"

module lpif_link_tb
  import lpif_link_pkg::*;
  import phy_lane_pkg::*;
();

  localparam int HALF_PERIOD = 4;
  localparam int PAYLOAD_W   = `LANE_WIDTH - 2;
  localparam int STREAM_W    = $bits(lpif_stream_t);
  localparam int RAISE_LIMIT = 40;
  localparam int LOOP_WORDS  = 200;
  localparam int TEST_CYCLES = 8 + 2 * RAISE_LIMIT + LOOP_WORDS + 8 + 2 * STREAM_W + 24;
  // Worst case of both sync FSMs counting from the largest delays
  localparam int WATCHDOG_NS = (TEST_CYCLES + 3 * 255) * 2 * HALF_PERIOD + 2000;

  logic         clk_wr = 1'b0;
  logic         arst_n;
  logic         tx_online;
  logic         rx_online;
  delay_t       delay_x_value;
  delay_t       delay_xz_value;
  delay_t       delay_yz_value;
  lpif_stream_t upstream;
  lpif_stream_t downstream;
  lane_bus_t    tx_lanes;
  lane_bus_t    rx_lanes;
  dbg_count_t   tx_debug_status;
  dbg_count_t   rx_debug_status;

  // Reference model state
  lpif_stream_t exp_down = '0;
  lane_bus_t    exp_lanes = '0;
  lpif_stream_t sent_q[$];
  logic         tx_ok_q[$];
  int           tx_run = 0;
  int           rx_run = 0;
  logic         tx_on_m = 1'b0;
  logic         rx_on_m = 1'b0;
  int           tx_count_m = 0;
  int           rx_count_m = 0;

  string        cur_test = "none";
  int           test_errs = 0;
  int           err_count = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;

  always #(HALF_PERIOD) clk_wr = ~clk_wr;

  // External lane loopback
  assign rx_lanes = tx_lanes;

  lpif_link_top dut (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .upstream        (upstream),
    .downstream      (downstream),
    .tx_lanes        (tx_lanes),
    .rx_lanes        (rx_lanes),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Word seen downstream, fields hold while the link is not usable
  function automatic lpif_stream_t expect_word(input lpif_stream_t sent, input logic tx_ok,
                                               input logic rx_ok, input lpif_stream_t prev);
    lpif_stream_t r;
    if (tx_ok && rx_ok) begin
      r = sent;
    end else begin
      r       = prev;
      r.valid = 1'b0;
    end
    return r;
  endfunction

  // Bit p of the link word goes to lane p/22, bit 2 + p%22
  function automatic lane_bus_t stripe_lanes(input lpif_stream_t w, input logic on);
    lane_bus_t           lanes;
    logic [STREAM_W-1:0] bits;
    lanes = '0;
    bits  = w;
    if (on) begin
      // Spare link bits above the stream stay zero
      for (int p = 0; p < STREAM_W; p++) begin
        lanes.lane[p / PAYLOAD_W][2 + p % PAYLOAD_W] = bits[p];
      end
      lanes.lane[0][0]             = 1'b1;
      lanes.lane[`LANE_COUNT-1][1] = 1'b1;
    end
    return lanes;
  endfunction

  always @(posedge clk_wr) begin
    lpif_stream_t w;
    logic         ok;
    if (!arst_n) begin
      exp_down   = '0;
      exp_lanes  = '0;
      sent_q.delete();
      tx_ok_q.delete();
      tx_run     = 0;
      rx_run     = 0;
      tx_on_m    = 1'b0;
      rx_on_m    = 1'b0;
      tx_count_m = 0;
      rx_count_m = 0;
    end else begin
      // Word that sat on the lanes since the previous edge
      if (sent_q.size() > 0) begin
        w        = sent_q.pop_front();
        ok       = tx_ok_q.pop_front();
        exp_down = expect_word(w, ok, rx_on_m, exp_down);
        if (exp_down.valid) rx_count_m++;
      end
      if (upstream.valid && tx_on_m) tx_count_m++;
      exp_lanes = stripe_lanes(upstream, tx_on_m);
      sent_q.push_back(upstream);
      tx_ok_q.push_back(tx_on_m);
      tx_run  = tx_online ? tx_run + 1 : 0;
      rx_run  = rx_online ? rx_run + 1 : 0;
      tx_on_m = (tx_run > int'(delay_xz_value));
      rx_on_m = (rx_run > int'(delay_x_value) + int'(delay_yz_value));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("Error: test %s, %s expected %0h actual %0h", cur_test, what, expected, actual);
      err_count++;
      test_errs++;
    end
  endtask

  always @(negedge clk_wr) begin
    check_value("downstream", 128'(exp_down), 128'(downstream));
    check_value("tx_lanes", 128'(exp_lanes), 128'(tx_lanes));
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic lpif_stream_t rand_word(input logic force_valid);
    lpif_stream_t w;
    logic [31:0]  r;
    r        = $urandom;
    w.state  = r[3:0];
    w.protid = r[5:4];
    w.bstart = r[8:6];
    w.bvalid = r[16:9];
    w.valid  = force_valid | r[17];
    w.data   = {$urandom, $urandom};
    return w;
  endfunction

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("Test %s passed", cur_test);
      tests_passed++;
    end else begin
      $display("Test %s failed with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  task automatic check_quiet();
    check_value("downstream.valid", '0, 128'(downstream.valid));
    check_value("tx_lanes", '0, 128'(tx_lanes));
    check_value("tx_debug_status", '0, 128'(tx_debug_status));
    check_value("rx_debug_status", '0, 128'(rx_debug_status));
  endtask

  // Cycle counts are taken from the first edge that samples the raised level
  task automatic raise_and_measure(input logic with_rx, output int first_stb,
                                   output int first_vld);
    int k;
    k         = 0;
    first_stb = -1;
    first_vld = -1;
    @(posedge clk_wr);
    #1;
    tx_online = 1'b1;
    if (with_rx) rx_online = 1'b1;
    upstream = rand_word(1'b1);
    while (k < RAISE_LIMIT && (first_stb < 0 || first_vld < 0)) begin
      @(posedge clk_wr);
      #1;
      upstream = rand_word(1'b1);
      @(negedge clk_wr);
      if (first_stb < 0 && tx_lanes.lane[0][0]) begin
        first_stb = k;
        check_value("marker on last lane", 128'(1), 128'(tx_lanes.lane[`LANE_COUNT-1][1]));
      end
      if (first_vld < 0 && downstream.valid) first_vld = k;
      k++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [STREAM_W-1:0] one_hot;
    int                  ones;
    int                  first_stb;
    int                  first_vld;
    int                  exp_vld;
    void'($urandom(32'h8286));
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 8'd3;
    delay_xz_value = 8'd5;
    delay_yz_value = 8'd4;
    upstream       = '0;

    start_test("reset");
    repeat (2) @(posedge clk_wr);
    @(negedge clk_wr);
    check_quiet();
    @(posedge clk_wr);
    #1;
    arst_n = 1'b1;
    @(negedge clk_wr);
    check_quiet();
    end_test();

    start_test("online_delay");
    raise_and_measure(1'b1, first_stb, first_vld);
    // Lane register adds one cycle after tx_online_delay rises
    check_value("first strobe cycle", 128'(int'(delay_xz_value) + 1), 128'(first_stb));
    // Needs strobed lanes and rx online, then the downstream register
    exp_vld = int'(delay_x_value) + int'(delay_yz_value) + 1;
    if (int'(delay_xz_value) + 2 > exp_vld) exp_vld = int'(delay_xz_value) + 2;
    check_value("first valid cycle", 128'(exp_vld), 128'(first_vld));
    end_test();

    start_test("loopback");
    repeat (LOOP_WORDS) begin
      @(posedge clk_wr);
      #1;
      upstream = rand_word(1'b0);
    end
    end_test();

    start_test("lane_striping");
    for (int p = 0; p < STREAM_W; p++) begin
      one_hot    = '0;
      one_hot[p] = 1'b1;
      @(posedge clk_wr);
      #1;
      upstream = one_hot;
      // Sampled at the next edge, on the lanes after it
      repeat (2) @(negedge clk_wr);
      ones = 0;
      for (int i = 0; i < `LANE_COUNT; i++) begin
        ones += $countones(tx_lanes.lane[i][`LANE_WIDTH-1:2]);
      end
      check_value($sformatf("payload ones for bit %0d", p), 128'(1), 128'(ones));
      check_value($sformatf("lane bit for bit %0d", p), 128'(1),
                  128'(tx_lanes.lane[p / PAYLOAD_W][2 + p % PAYLOAD_W]));
    end
    end_test();

    start_test("offline_drop");
    repeat (10) begin
      @(posedge clk_wr);
      #1;
      upstream = rand_word(1'b0);
    end
    @(posedge clk_wr);
    #1;
    tx_online = 1'b0;
    upstream  = rand_word(1'b1);
    // Before the sampling edge, after it, then one cycle later
    repeat (3) @(negedge clk_wr);
    check_value("tx_lanes after drop", '0, 128'(tx_lanes));
    repeat (6) begin
      @(posedge clk_wr);
      #1;
      upstream = rand_word(1'b1);
      @(negedge clk_wr);
      check_value("valid while offline", '0, 128'(downstream.valid));
    end
    raise_and_measure(1'b0, first_stb, first_vld);
    check_value("strobe cycle after restart", 128'(int'(delay_xz_value) + 1), 128'(first_stb));
    check_value("valid cycle after restart", 128'(int'(delay_xz_value) + 2), 128'(first_vld));
    end_test();

    start_test("debug_counters");
    repeat (4) begin
      @(posedge clk_wr);
      #1;
      upstream = '0;
    end
    @(negedge clk_wr);
    check_value("tx_debug_status", 128'(dbg_count_t'(tx_count_m)), 128'(tx_debug_status));
    check_value("rx_debug_status", 128'(dbg_count_t'(rx_count_m)), 128'(rx_debug_status));
    end_test();

    $display("Tests passed %0d, failed %0d, failed checks %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
